//--- Makefile
# any of these can be set on the command line, e.g. make test LOG=run.log
VERILATOR ?= verilator
TOP ?= tb_cdic
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/cdic_host_regs.sv
`default_nettype none

module cdic_host_regs (
    input wire logic clk,
    input wire logic reset,
    input wire cdic_pkg::word_addr_t address,
    input wire cdic_pkg::bus_word_t din,
    output cdic_pkg::bus_word_t dout,
    input wire logic uds,
    input wire logic lds,
    input wire logic write_strobe,
    input wire logic cs,
    output logic bus_ack,
    output logic intreq,
    input wire logic intack,

    output cdic_pkg::bank_addr_t rd_addr,
    input wire cdic_pkg::bus_word_t rd_data[cdic_pkg::NUM_BANKS],

    output logic read_start,
    output cdic_pkg::lba_t start_lba,
    output logic read_stop,
    output logic stop_after_sector,
    input wire logic sector_done,
    input wire logic ready_bank
);
    import cdic_pkg::*;

    bus_word_t command_reg;
    time_reg_t time_reg;
    bus_word_t xbuf_reg;  // bit 15 is the sector interrupt
    bus_word_t ivec_reg;
    logic [15:1] dbuf_reg;  // bit 0 comes from ready_bank
    logic access;
    logic wr_cycle;
    logic rd_cycle;
    logic ram_hit;
    bank_sel_t ram_bank;

    assign access = cs && uds && lds;
    assign wr_cycle = access && write_strobe && bus_ack;
    assign rd_cycle = access && !write_strobe && bus_ack;
    assign intreq = xbuf_reg[15];

    // mm:ss:ff to block address
    always_comb begin
        lba_t mins;
        lba_t secs;
        lba_t frames;

        mins = lba_t'(time_reg.bcd.min_tens) * 10 + lba_t'(time_reg.bcd.min_ones);
        secs = lba_t'(time_reg.bcd.sec_tens) * 10 + lba_t'(time_reg.bcd.sec_ones);
        frames = lba_t'(time_reg.bcd.frm_tens) * 10 + lba_t'(time_reg.bcd.frm_ones);
        start_lba = (mins * 60 + secs) * 75 + frames;
    end

    // which bank a RAM offset falls into
    always_comb begin
        ram_hit = 1'b0;
        ram_bank = '0;
        rd_addr = bank_addr_t'(address);
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (address < REG_BASE &&
                address >= word_addr_t'(b * BANK_WORDS) &&
                address < word_addr_t'((b + 1) * BANK_WORDS)) begin
                ram_hit = 1'b1;
                ram_bank = bank_sel_t'(b);
                rd_addr = bank_addr_t'(address - word_addr_t'(b * BANK_WORDS));
            end
        end
    end

    always_ff @(posedge clk) begin
        read_start <= 1'b0;
        read_stop <= 1'b0;
        stop_after_sector <= 1'b0;

        if (reset) begin
            bus_ack <= 1'b0;
            command_reg <= '0;
            time_reg <= '0;
            xbuf_reg <= '0;
            ivec_reg <= '0;
            dbuf_reg <= '0;
        end else begin
            bus_ack <= access ? ~bus_ack : 1'b0;  // toggles while held

            // command runs the cycle after DBUF bit 15 is written
            if (dbuf_reg[15]) begin
                dbuf_reg[15] <= 1'b0;
                case (cdic_cmd_e'(command_reg))
                    CMD_READ_MODE1, CMD_READ_MODE2: read_start <= 1'b1;
                    CMD_RESET_MODE1, CMD_RESET_MODE2: stop_after_sector <= 1'b1;
                    CMD_STOP_CDDA, CMD_UPDATE: read_stop <= 1'b1;
                    default: begin
                    end
                endcase
            end

            if (rd_cycle && address == REG_XBUF) xbuf_reg[15] <= 1'b0;  // read still saw it set

            if (wr_cycle) begin
                case (address)
                    REG_COMMAND: command_reg <= din;
                    REG_TIME_HIGH: time_reg.half.high <= din;
                    REG_TIME_LOW: time_reg.half.low <= din;
                    REG_XBUF: xbuf_reg <= din;
                    REG_IVEC: ivec_reg <= din;
                    REG_DBUF: begin
                        dbuf_reg <= din[15:1];
                        if (!din[14]) read_stop <= 1'b1;  // drops out of reading
                    end
                    default: begin
                    end
                endcase
            end

            if (sector_done) xbuf_reg[15] <= 1'b1;
        end
    end

    always_comb begin
        case (address)
            REG_COMMAND: dout = command_reg;
            REG_TIME_HIGH: dout = time_reg.half.high;
            REG_TIME_LOW: dout = time_reg.half.low;
            REG_XBUF: dout = xbuf_reg;
            REG_IVEC: dout = ivec_reg;
            REG_DBUF: dout = {dbuf_reg, ready_bank};
            default: dout = ram_hit ? rd_data[ram_bank] : '0;  // valid on the bus_ack cycle
        endcase

        // vector fetch during interrupt acknowledge
        if (intack) dout = {ivec_reg[7:0], ivec_reg[7:0]};
    end

    // host must only trigger commands this controller implements
    a_known_command :
    assert property (@(posedge clk) disable iff (reset)
        dbuf_reg[15] |-> command_reg inside {CMD_RESET_MODE1, CMD_RESET_MODE2,
                                             CMD_READ_MODE1, CMD_READ_MODE2,
                                             CMD_STOP_CDDA, CMD_UPDATE});

endmodule

`default_nettype wire

//--- design/cdic_pkg.sv
`default_nettype none

package cdic_pkg;

    typedef logic [12:0] word_addr_t;  // address bits 13:1
    typedef logic [15:0] bus_word_t;
    typedef logic [31:0] lba_t;

    parameter int WORDS_PER_SECTOR = 1176;  // 2352 bytes
    parameter int SYNC_WORDS = 6;
    parameter int BANK_WORDS = 1280;  // bank 1 starts at host offset 0x500
    parameter int NUM_BANKS = 2;
    parameter int BANK_SEL_W = $clog2(NUM_BANKS);

    typedef logic [10:0] bank_addr_t;
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;

    // register word offsets
    parameter word_addr_t REG_BASE = 13'h1E00;  // below this is sector RAM
    parameter word_addr_t REG_COMMAND = 13'h1E00;
    parameter word_addr_t REG_TIME_HIGH = 13'h1E01;
    parameter word_addr_t REG_TIME_LOW = 13'h1E02;
    parameter word_addr_t REG_XBUF = 13'h1FFB;
    parameter word_addr_t REG_IVEC = 13'h1FFE;
    parameter word_addr_t REG_DBUF = 13'h1FFF;

    typedef enum logic [15:0] {
        CMD_RESET_MODE1 = 16'h0023,
        CMD_RESET_MODE2 = 16'h0024,
        CMD_READ_MODE1  = 16'h0029,
        CMD_READ_MODE2  = 16'h002A,
        CMD_STOP_CDDA   = 16'h002B,
        CMD_UPDATE      = 16'h002E
    } cdic_cmd_e;

    // time register, written as two halves, decoded as mm:ss:ff in BCD
    typedef union packed {
        struct packed {
            logic [3:0] min_tens;
            logic [3:0] min_ones;
            logic [3:0] sec_tens;
            logic [3:0] sec_ones;
            logic [3:0] frm_tens;
            logic [3:0] frm_ones;
            logic [7:0] reserved;
        } bcd;
        struct packed {
            bus_word_t high;
            bus_word_t low;
        } half;
    } time_reg_t;

endpackage

`default_nettype wire

//--- design/cdic_sector_bank.sv
`default_nettype none

module cdic_sector_bank #(
    parameter int bank_index = 0
) (
    input wire logic clk,
    input wire cdic_pkg::bank_addr_t rd_addr,
    output cdic_pkg::bus_word_t rd_data,
    sector_wr_if.bank_mp wr
);
    import cdic_pkg::*;

    localparam bank_sel_t OWN_BANK = bank_sel_t'(bank_index);

    bus_word_t mem[BANK_WORDS];
    logic wr_hit;

    assign wr_hit = wr.wr_en && wr.wr_bank == OWN_BANK;

    always_ff @(posedge clk) begin
        if (wr_hit) mem[wr.wr_addr] <= wr.wr_data;
    end

    // host side, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // the reader's address counter must stay inside the bank
    a_wr_in_range :
    assert property (@(posedge clk)
        wr_hit |-> wr.wr_addr < bank_addr_t'(BANK_WORDS));

endmodule

`default_nettype wire

//--- design/cdic_sector_reader.sv
`default_nettype none

module cdic_sector_reader #(
    parameter int sector_period = 300000
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic read_start,  // pulse, loads start_lba
    input wire cdic_pkg::lba_t start_lba,
    input wire logic read_stop,  // pulse, stop at once
    input wire logic stop_after_sector,  // pulse, also loads start_lba
    output logic cd_hps_req,
    input wire logic cd_hps_ack,
    input wire logic cd_hps_data_valid,
    input wire cdic_pkg::bus_word_t cd_hps_data,
    output cdic_pkg::lba_t cd_hps_lba,
    output logic sector_done,
    output logic ready_bank,  // bank holding the last full sector
    sector_wr_if.reader_mp wr
);
    import cdic_pkg::*;

    localparam int TIMER_W = $clog2(sector_period);
    localparam int IDX_W = $clog2(WORDS_PER_SECTOR + 1);
    localparam logic [IDX_W-1:0] IDX_IDLE = IDX_W'(WORDS_PER_SECTOR);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(WORDS_PER_SECTOR - 1);
    localparam logic [IDX_W-1:0] IDX_FIRST_DATA = IDX_W'(SYNC_WORDS);

    logic [TIMER_W-1:0] sector_timer;  // models the disc rotation
    logic reading;
    logic stop_pending;
    logic [IDX_W-1:0] word_idx;  // sits at IDX_IDLE between sectors
    bank_addr_t fill_addr;
    bank_sel_t fill_bank;
    logic in_sector;
    logic payload_word;

    assign in_sector = word_idx < IDX_IDLE;
    assign payload_word = cd_hps_data_valid && in_sector && word_idx >= IDX_FIRST_DATA;

    // free running, independent of reading
    always_ff @(posedge clk) begin
        if (reset || sector_timer == '0) begin
            sector_timer <= TIMER_W'(sector_period - 1);
        end else begin
            sector_timer <= sector_timer - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        sector_done <= 1'b0;

        if (reset) begin
            reading <= 1'b0;
            stop_pending <= 1'b0;
            cd_hps_req <= 1'b0;
            cd_hps_lba <= '0;
            word_idx <= IDX_IDLE;
            fill_addr <= '0;
            fill_bank <= '0;
            ready_bank <= 1'b0;
        end else begin
            if (cd_hps_ack) cd_hps_req <= 1'b0;

            if (cd_hps_data_valid && in_sector) begin
                word_idx <= word_idx + 1'b1;
                if (payload_word) fill_addr <= fill_addr + 1'b1;  // sync words skipped

                if (word_idx == IDX_LAST) begin
                    ready_bank <= ~ready_bank;
                    cd_hps_lba <= cd_hps_lba + 1'b1;
                    sector_done <= 1'b1;
                    if (stop_pending) begin
                        reading <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end

            // one cycle ahead of the timer wrap
            if (reading && sector_timer == TIMER_W'(1)) begin
                cd_hps_req <= 1'b1;
                word_idx <= '0;
                fill_addr <= '0;
                fill_bank <= bank_sel_t'(~ready_bank);
            end

            if (stop_after_sector) begin
                cd_hps_lba <= start_lba;
                stop_pending <= reading;
            end

            if (read_stop) begin
                reading <= 1'b0;
                stop_pending <= 1'b0;
            end

            if (read_start) begin
                reading <= 1'b1;
                stop_pending <= 1'b0;
                cd_hps_lba <= start_lba;
            end
        end
    end

    assign wr.wr_en = payload_word;
    assign wr.wr_bank = fill_bank;
    assign wr.wr_addr = fill_addr;
    assign wr.wr_data = cd_hps_data;

    // drive must not send more than one sector per request
    a_no_word_past_sector :
    assert property (@(posedge clk) disable iff (reset)
        cd_hps_data_valid |-> word_idx != IDX_IDLE);

endmodule

`default_nettype wire

//--- design/cdic_top.sv
`default_nettype none

module cdic_top #(
    parameter int sector_period = 300000  // clocks per sector
) (
    input wire logic clk,
    input wire logic reset,
    input wire cdic_pkg::word_addr_t address,
    input wire cdic_pkg::bus_word_t din,
    output cdic_pkg::bus_word_t dout,
    input wire logic uds,
    input wire logic lds,
    input wire logic write_strobe,
    input wire logic cs,
    output logic bus_ack,
    output logic intreq,
    input wire logic intack,

    output cdic_pkg::lba_t cd_hps_lba,
    output logic cd_hps_req,
    input wire logic cd_hps_ack,
    input wire logic cd_hps_data_valid,
    input wire cdic_pkg::bus_word_t cd_hps_data
);
    import cdic_pkg::*;

    logic read_start;
    lba_t start_lba;
    logic read_stop;
    logic stop_after_sector;
    logic sector_done;
    logic ready_bank;
    bank_addr_t rd_addr;
    bus_word_t bank_rd_data[NUM_BANKS];

    sector_wr_if sector_wr ();

    cdic_sector_reader #(
        .sector_period(sector_period)
    ) i_sector_reader (
        .clk(clk),
        .reset(reset),
        .read_start(read_start),
        .start_lba(start_lba),
        .read_stop(read_stop),
        .stop_after_sector(stop_after_sector),
        .cd_hps_req(cd_hps_req),
        .cd_hps_ack(cd_hps_ack),
        .cd_hps_data_valid(cd_hps_data_valid),
        .cd_hps_data(cd_hps_data),
        .cd_hps_lba(cd_hps_lba),
        .sector_done(sector_done),
        .ready_bank(ready_bank),
        .wr(sector_wr.reader_mp)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        cdic_sector_bank #(
            .bank_index(i)
        ) i_sector_bank (
            .clk(clk),
            .rd_addr(rd_addr),
            .rd_data(bank_rd_data[i]),
            .wr(sector_wr.bank_mp)
        );
    end

    cdic_host_regs i_host_regs (
        .clk(clk),
        .reset(reset),
        .address(address),
        .din(din),
        .dout(dout),
        .uds(uds),
        .lds(lds),
        .write_strobe(write_strobe),
        .cs(cs),
        .bus_ack(bus_ack),
        .intreq(intreq),
        .intack(intack),
        .rd_addr(rd_addr),
        .rd_data(bank_rd_data),
        .read_start(read_start),
        .start_lba(start_lba),
        .read_stop(read_stop),
        .stop_after_sector(stop_after_sector),
        .sector_done(sector_done),
        .ready_bank(ready_bank)
    );

endmodule

`default_nettype wire

//--- design/sector_wr_if.sv
`default_nettype none

// sector words from the reader toward the banks, no back-pressure
interface sector_wr_if;
    import cdic_pkg::*;

    logic wr_en;  // one word per cycle while high
    bank_sel_t wr_bank;  // only the matching bank stores
    bank_addr_t wr_addr;
    bus_word_t wr_data;

    modport reader_mp(
        output wr_en,
        output wr_bank,
        output wr_addr,
        output wr_data
    );

    modport bank_mp(
        input wr_en,
        input wr_bank,
        input wr_addr,
        input wr_data
    );

endinterface

`default_nettype wire

//--- dv/tb_cdic.sv
`default_nettype none

module tb_cdic;
    timeunit 1ns;
    timeprecision 1ns;

    import cdic_pkg::*;

    localparam int SECTOR_PERIOD = 2000;
    localparam int TIMEOUT_CYCLES = 6 * SECTOR_PERIOD + SECTOR_PERIOD;
    localparam int PAYLOAD_WORDS = WORDS_PER_SECTOR - SYNC_WORDS;
    localparam word_addr_t REG_ADDRS[6] = '{REG_COMMAND, REG_TIME_HIGH, REG_TIME_LOW,
                                            REG_XBUF, REG_IVEC, REG_DBUF};
    // xbuf bit 15 clear, dbuf bit 15 clear and bit 14 set
    localparam bus_word_t TEST_VALUES[6] = '{16'h1357, 16'h2468, 16'h9ABC,
                                             16'h1234, 16'h00A5, 16'h5A5A};
    string reg_names[6] = '{"command", "time_high", "time_low", "xbuf", "ivec", "dbuf"};

    logic clk;
    logic reset;
    word_addr_t address;
    bus_word_t din;
    bus_word_t dout;
    logic uds;
    logic lds;
    logic write_strobe;
    logic cs;
    logic bus_ack;
    logic intreq;
    logic intack;
    lba_t cd_hps_lba;
    logic cd_hps_req;
    logic cd_hps_ack;
    logic cd_hps_data_valid;
    bus_word_t cd_hps_data;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int req_count = 0;
    lba_t first_req_lba;
    logic [31:0] rng_state;

    // sector RAM words waiting for the compare process
    lba_t ram_lba_q[$];
    int ram_idx_q[$];
    bus_word_t ram_data_q[$];

    cdic_top #(
        .sector_period(SECTOR_PERIOD)
    ) i_cdic_top (
        .clk(clk),
        .reset(reset),
        .address(address),
        .din(din),
        .dout(dout),
        .uds(uds),
        .lds(lds),
        .write_strobe(write_strobe),
        .cs(cs),
        .bus_ack(bus_ack),
        .intreq(intreq),
        .intack(intack),
        .cd_hps_lba(cd_hps_lba),
        .cd_hps_req(cd_hps_req),
        .cd_hps_ack(cd_hps_ack),
        .cd_hps_data_valid(cd_hps_data_valid),
        .cd_hps_data(cd_hps_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // sector contents of the CD image
    function automatic bus_word_t expected_word(input lba_t lba, input int idx);
        logic [31:0] scrambled;
        scrambled = idx * 32'h9E37;
        return lba[15:0] ^ scrambled[15:0];
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_counts();
        $display("checks: %0d  errors: %0d", checks, errors);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic end_access();
        cs = 1'b0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic host_write(input word_addr_t addr, input bus_word_t data);
        address = addr;
        din = data;
        write_strobe = 1'b1;
        cs = 1'b1;
        uds = 1'b1;
        lds = 1'b1;
        @(negedge clk);
        while (!bus_ack) @(negedge clk);
        @(negedge clk);  // write edge has passed
        check_equal("bus_ack", 32'(bus_ack), 32'd0);  // toggled back
        end_access();
    endtask

    task automatic host_read(input word_addr_t addr, output bus_word_t data);
        address = addr;
        write_strobe = 1'b0;
        cs = 1'b1;
        uds = 1'b1;
        lds = 1'b1;
        @(negedge clk);
        while (!bus_ack) @(negedge clk);
        data = dout;  // bank data lands with bus_ack
        @(negedge clk);
        check_equal("bus_ack", 32'(bus_ack), 32'd0);
        end_access();
    endtask

    task automatic read_check(input string name, input word_addr_t addr, input bus_word_t exp);
        bus_word_t data;
        host_read(addr, data);
        check_equal(name, 32'(data), 32'(exp));
    endtask

    // whole payload of one bank, queued for comparison
    task automatic read_sector(input int base, input lba_t lba);
        bus_word_t data;
        for (int k = 0; k < PAYLOAD_WORDS; k++) begin
            host_read(word_addr_t'(base + k), data);
            ram_lba_q.push_back(lba);
            ram_idx_q.push_back(k + SYNC_WORDS);
            ram_data_q.push_back(data);
        end
    endtask

    // drive model, one sector per request
    initial begin
        lba_t sector_lba;
        int delay;
        cd_hps_ack = 1'b0;
        cd_hps_data_valid = 1'b0;
        cd_hps_data = '0;
        rng_state = 32'd91;
        forever begin
            @(negedge clk);
            if (cd_hps_req) begin
                sector_lba = cd_hps_lba;
                if (req_count == 0) first_req_lba = cd_hps_lba;
                req_count++;
                rng_state = xorshift32(rng_state);
                delay = 1 + int'(rng_state[2:0]);
                repeat (delay) @(negedge clk);
                cd_hps_ack = 1'b1;
                @(negedge clk);
                cd_hps_ack = 1'b0;
                for (int idx = 0; idx < WORDS_PER_SECTOR; idx++) begin
                    rng_state = xorshift32(rng_state);
                    if (rng_state[3:0] == 4'd0) begin  // one idle cycle now and then
                        cd_hps_data_valid = 1'b0;
                        @(negedge clk);
                    end
                    cd_hps_data_valid = 1'b1;
                    cd_hps_data = expected_word(sector_lba, idx);
                    @(negedge clk);
                end
                cd_hps_data_valid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin : compare_ram
        lba_t lba;
        int idx;
        bus_word_t got;
        while (ram_data_q.size() > 0) begin
            lba = ram_lba_q.pop_front();
            idx = ram_idx_q.pop_front();
            got = ram_data_q.pop_front();
            check_equal($sformatf("dout at word index %0d", idx), 32'(got),
                        32'(expected_word(lba, idx)));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        bus_word_t data;
        lba_t start_lba;
        lba_t stop_lba;
        int stop_reqs;
        int stop_cycle;

        reset = 1'b1;
        address = '0;
        din = '0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
        cs = 1'b0;
        intack = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_equal("bus_ack", 32'(bus_ack), 32'd0);
        check_equal("cd_hps_req", 32'(cd_hps_req), 32'd0);
        for (int r = 0; r < 6; r++) read_check(reg_names[r], REG_ADDRS[r], 16'h0000);
        check_equal("intreq", 32'(intreq), 32'd0);
        for (int r = 0; r < 6; r++) host_write(REG_ADDRS[r], TEST_VALUES[r]);
        for (int r = 0; r < 6; r++) read_check(reg_names[r], REG_ADDRS[r], TEST_VALUES[r]);

        intack = 1'b1;  // vector fetch
        @(negedge clk);
        check_equal("dout", 32'(dout), 32'h0000A5A5);
        intack = 1'b0;

        // 01:02:03 then read mode 1
        start_lba = 32'd4653;
        host_write(REG_TIME_HIGH, 16'h0102);
        host_write(REG_TIME_LOW, 16'h0300);
        host_write(REG_COMMAND, 16'h0029);
        host_write(REG_DBUF, 16'hC000);
        while (req_count == 0) @(negedge clk);
        check_equal("cd_hps_lba", first_req_lba, start_lba);

        // first sector in bank 1
        while (!intreq) @(negedge clk);
        host_read(REG_DBUF, data);
        check_equal("dbuf bit 0", 32'(data[0]), 32'd1);
        host_read(REG_XBUF, data);
        check_equal("xbuf bit 15", 32'(data[15]), 32'd1);
        check_equal("intreq", 32'(intreq), 32'd0);
        read_sector(BANK_WORDS, start_lba);

        // second sector in bank 0, then stop before a third one starts
        while (!intreq) @(negedge clk);
        host_read(REG_DBUF, data);
        check_equal("dbuf bit 0", 32'(data[0]), 32'd0);
        host_read(REG_XBUF, data);
        check_equal("xbuf bit 15", 32'(data[15]), 32'd1);
        host_write(REG_DBUF, 16'h0000);
        stop_lba = cd_hps_lba;
        stop_reqs = req_count;
        stop_cycle = cycles;
        check_equal("cd_hps_lba", stop_lba, start_lba + 2);
        read_sector(0, start_lba + 1);

        while (cycles - stop_cycle < 2 * SECTOR_PERIOD) @(negedge clk);
        checks++;
        assert (req_count == stop_reqs && !cd_hps_req) else begin
            errors++;
            $display("a sector request was made after reading was stopped");
        end
        check_equal("cd_hps_lba", cd_hps_lba, stop_lba);

        while (ram_data_q.size() > 0) @(negedge clk);
        @(negedge clk);
        report_counts();
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
design/cdic_pkg.sv
design/sector_wr_if.sv
design/cdic_sector_reader.sv
design/cdic_sector_bank.sv
design/cdic_host_regs.sv
design/cdic_top.sv
dv/tb_cdic.sv
